// ==== hdl/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Data and register width.
`define MEM_DATA_W 32

// Byte address width, covers the whole memory.
`define MEM_ADDR_W 12

// Number of 32-bit words in the data memory.
`define MEM_DEPTH_WORDS 1024

// Register file index width.
`define MEM_REG_W 5

// Cycles from read request to response.
`define MEM_RD_LAT 2

`endif

// ==== hdl/mem_types_pkg.sv ====
`include "mem_params.svh"

package mem_types_pkg;

  typedef logic [`MEM_DATA_W-1:0] data_t;

  typedef logic [`MEM_ADDR_W-1:0] addr_t;

  typedef logic [`MEM_REG_W-1:0] reg_idx_t;

  // One bit per byte lane.
  typedef logic [`MEM_DATA_W/8-1:0] byte_en_t;

  // Encoded like the RISC-V load/store funct3 field.
  typedef enum logic [2:0] {
    SIZE_B  = 3'b000,
    SIZE_H  = 3'b001,
    SIZE_W  = 3'b010,
    SIZE_BU = 3'b100,
    SIZE_HU = 3'b101
  } access_size_t;

endpackage : mem_types_pkg

// ==== hdl/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // Bundle from the execute stage.
  typedef struct packed {
    logic                       valid;
    logic                       is_load;
    logic                       is_store;
    logic                       reg_wr_en;
    mem_types_pkg::access_size_t access_size;
    mem_types_pkg::data_t        alu_result;
    mem_types_pkg::data_t        rs2_data;
    mem_types_pkg::reg_idx_t     wr_reg;
  } ex_mem_t;

  // Single-cycle request strobes, no ready.
  typedef struct packed {
    logic                        rd;
    logic                        wr;
    mem_types_pkg::addr_t        addr;
    mem_types_pkg::data_t        wdata;
    mem_types_pkg::access_size_t size;
  } mem_req_t;

  typedef struct packed {
    logic                 valid;
    mem_types_pkg::data_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                    valid;
    logic                    reg_wr_en;
    mem_types_pkg::reg_idx_t wr_reg;
    mem_types_pkg::data_t    data;
  } wb_t;

endpackage : mem_bus_pkg

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module mem_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  mem_bus_pkg::ex_mem_t  ex_i,
  input  logic                  rsp_valid_i,
  output mem_bus_pkg::mem_req_t req_o,
  output logic                  stall_o,
  output mem_bus_pkg::wb_t      wb_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state_q;
  state_t state_d;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    // Address, data and size follow the held bundle.
    req_o.rd       = 1'b0;
    req_o.wr       = 1'b0;
    req_o.addr     = ex_i.alu_result[`MEM_ADDR_W-1:0];
    req_o.wdata    = ex_i.rs2_data;
    req_o.size     = ex_i.access_size;
    wb_o.valid     = 1'b0;
    wb_o.reg_wr_en = 1'b0;
    wb_o.wr_reg    = ex_i.wr_reg;
    wb_o.data      = ex_i.alu_result;
    stall_o        = 1'b0;
    state_d        = state_q;

    unique case (state_q)
      IDLE: begin
        // Hold off upstream for the first cycle out of reset.
        stall_o = 1'b1;
        state_d = READY;
      end
      READY: begin
        if (ex_i.valid) begin
          req_o.rd       = ex_i.is_load;
          req_o.wr       = ex_i.is_store;
          wb_o.valid     = !ex_i.is_load;
          wb_o.reg_wr_en = ex_i.is_load ? 1'b0 : ex_i.reg_wr_en;
          stall_o        = ex_i.is_load;
          state_d        = ex_i.is_load ? WAITING : READY;
        end
      end
      WAITING: begin
        stall_o = 1'b1;
        if (rsp_valid_i) begin
          wb_o.valid     = 1'b1;
          wb_o.reg_wr_en = 1'b1;
          stall_o        = 1'b0;
          state_d        = READY;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  a_req_only_in_ready : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    (req_o.rd || req_o.wr) |-> (state_q == READY)
  );

  a_rd_wr_exclusive : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    !(req_o.rd && req_o.wr)
  );

  // The memory must answer a read after exactly the fixed latency.
  a_rsp_after_rd : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    req_o.rd |-> ##(`MEM_RD_LAT) rsp_valid_i
  );

endmodule : mem_stage

// ==== hdl/dmem.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module dmem (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  mem_bus_pkg::mem_req_t req_i,
  output mem_bus_pkg::mem_rsp_t rsp_o
);

  import mem_types_pkg::*;

  localparam int word_idx_w = $clog2(`MEM_DEPTH_WORDS);
  localparam int lanes      = `MEM_DATA_W / 8;

  data_t mem_q [`MEM_DEPTH_WORDS];

  logic                  pipe_valid_q [`MEM_RD_LAT];
  data_t                 pipe_data_q  [`MEM_RD_LAT];
  logic [word_idx_w-1:0] word_idx;
  logic [1:0]            byte_off;
  byte_en_t              byte_en;
  data_t                 wdata_sh;

  assign word_idx = req_i.addr[word_idx_w+1:2];
  assign byte_off = req_i.addr[1:0];

  // Lane enables from the access size.
  always_comb begin
    unique case (req_i.size)
      SIZE_B, SIZE_BU: byte_en = byte_en_t'(4'b0001) << byte_off;
      SIZE_H, SIZE_HU: byte_en = byte_en_t'(4'b0011) << byte_off;
      default:         byte_en = '1;
    endcase
  end

  assign wdata_sh = req_i.wdata << (8 * byte_off);

  always_ff @(posedge clk_i) begin
    if (req_i.wr) begin
      for (int i = 0; i < lanes; i++) begin
        if (byte_en[i]) begin
          mem_q[word_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
        end
      end
    end
  end

  // Read data is captured at request time and shifted down the pipe.
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `MEM_RD_LAT; i++) begin
        pipe_valid_q[i] <= 1'b0;
      end
    end else begin
      pipe_valid_q[0] <= req_i.rd;
      for (int i = 1; i < `MEM_RD_LAT; i++) begin
        pipe_valid_q[i] <= pipe_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pipe_data_q[0] <= mem_q[word_idx];
    for (int i = 1; i < `MEM_RD_LAT; i++) begin
      pipe_data_q[i] <= pipe_data_q[i-1];
    end
  end

  assign rsp_o.valid = pipe_valid_q[`MEM_RD_LAT-1];
  assign rsp_o.rdata = pipe_data_q[`MEM_RD_LAT-1];

  // No trap logic, so misaligned accesses are illegal.
  a_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    (req_i.rd || req_i.wr) |->
      (!(req_i.size inside {SIZE_H, SIZE_HU}) || (req_i.addr[0] == 1'b0)) &&
      ((req_i.size != SIZE_W) || (req_i.addr[1:0] == 2'b00))
  );

endmodule : dmem

// ==== hdl/load_align.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module load_align (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  mem_bus_pkg::wb_t            wb_i,
  input  mem_types_pkg::data_t        rdata_i,
  input  logic                        is_load_i,
  input  mem_types_pkg::access_size_t size_i,
  input  logic [1:0]                  offset_i,
  output mem_bus_pkg::wb_t            wb_o
);

  import mem_types_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  data_t       load_val;
  data_t       wb_data_d;

  assign sel_byte = rdata_i[8*offset_i +: 8];
  assign sel_half = rdata_i[16*offset_i[1] +: 16];

  always_comb begin
    unique case (size_i)
      SIZE_B:  load_val = {{(`MEM_DATA_W-8){sel_byte[7]}}, sel_byte};
      SIZE_BU: load_val = {{(`MEM_DATA_W-8){1'b0}}, sel_byte};
      SIZE_H:  load_val = {{(`MEM_DATA_W-16){sel_half[15]}}, sel_half};
      SIZE_HU: load_val = {{(`MEM_DATA_W-16){1'b0}}, sel_half};
      default: load_val = rdata_i;
    endcase
  end

  // Non-loads carry the ALU result.
  assign wb_data_d = is_load_i ? load_val : wb_i.data;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_o.valid     <= 1'b0;
      wb_o.reg_wr_en <= 1'b0;
    end else begin
      wb_o.valid     <= wb_i.valid;
      wb_o.reg_wr_en <= wb_i.reg_wr_en;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_o.wr_reg <= wb_i.wr_reg;
    wb_o.data   <= wb_data_d;
  end

endmodule : load_align

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  mem_bus_pkg::ex_mem_t ex_i,
  output logic                 stall_o,
  output mem_bus_pkg::wb_t     wb_o
);

  import mem_bus_pkg::*;

  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  wb_t      wb_strobe;

  mem_stage u_mem_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ex_i        (ex_i),
    .rsp_valid_i (mem_rsp.valid),
    .req_o       (mem_req),
    .stall_o     (stall_o),
    .wb_o        (wb_strobe)
  );

  dmem u_dmem (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  // Size and offset come from the bundle held during the load.
  load_align u_load_align (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wb_i      (wb_strobe),
    .rdata_i   (mem_rsp.rdata),
    .is_load_i (ex_i.is_load),
    .size_i    (ex_i.access_size),
    .offset_i  (ex_i.alu_result[1:0]),
    .wb_o      (wb_o)
  );

endmodule : mem_subsys_top

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/1ps

`include "mem_params.svh"

module tb_mem_subsys;

  import mem_types_pkg::*;
  import mem_bus_pkg::*;

  localparam int timeout_cycles = 20;

  typedef struct packed {
    wb_t         wb;
    logic [31:0] cycle;
  } exp_t;

  logic        clk_i;
  logic        rst_i;
  ex_mem_t     ex;
  logic        stall;
  wb_t         wb;
  logic [7:0]  model_mem [1 << `MEM_ADDR_W];
  exp_t        exp_q [$];
  logic [31:0] cycle_cnt;
  int          seed;
  int          errors;
  int          test_start;
  int          tests_run;
  int          tests_failed;

  mem_subsys_top dut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .ex_i    (ex),
    .stall_o (stall),
    .wb_o    (wb)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp_val, got_val);
    errors++;
  endtask

  function automatic ex_mem_t make_op(input logic ld, input logic st, input access_size_t size,
                                      input data_t alu, input data_t rs2, input logic wr_en);
    return '{valid: 1'b1, is_load: ld, is_store: st, reg_wr_en: wr_en, access_size: size,
             alu_result: alu, rs2_data: rs2, wr_reg: alu[4:0] ^ rs2[4:0]};
  endfunction

  // Little-endian byte model; loads extend by size, stores update the model.
  function automatic wb_t expected_wb(input ex_mem_t op);
    wb_t        res;
    addr_t      a;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    a   = op.alu_result[`MEM_ADDR_W-1:0];
    b0  = model_mem[a];
    b1  = model_mem[a + addr_t'(1)];
    b2  = model_mem[a + addr_t'(2)];
    b3  = model_mem[a + addr_t'(3)];
    res = '{valid: 1'b1, reg_wr_en: op.reg_wr_en | op.is_load, wr_reg: op.wr_reg,
            data: op.alu_result};
    if (op.is_load) begin
      case (op.access_size)
        SIZE_B:  res.data = {{24{b0[7]}}, b0};
        SIZE_BU: res.data = {24'h0, b0};
        SIZE_H:  res.data = {{16{b1[7]}}, b1, b0};
        SIZE_HU: res.data = {16'h0, b1, b0};
        default: res.data = {b3, b2, b1, b0};
      endcase
    end else if (op.is_store) begin
      model_mem[a] = op.rs2_data[7:0];
      if (op.access_size inside {SIZE_H, SIZE_HU, SIZE_W}) begin
        model_mem[a + addr_t'(1)] = op.rs2_data[15:8];
      end
      if (op.access_size == SIZE_W) begin
        model_mem[a + addr_t'(2)] = op.rs2_data[23:16];
        model_mem[a + addr_t'(3)] = op.rs2_data[31:24];
      end
    end
    return res;
  endfunction

  function automatic ex_mem_t random_op();
    ex_mem_t      op;
    data_t        r;
    data_t        addr;
    access_size_t size;
    r = $random(seed);
    case (r[4:2])
      3'd0:    size = SIZE_B;
      3'd1:    size = SIZE_BU;
      3'd2:    size = SIZE_H;
      3'd3:    size = SIZE_HU;
      default: size = SIZE_W;
    endcase
    // Aligned offset inside the 128-byte window at 0x400.
    addr = 32'h400 + {25'h0, r[11:5]};
    if (size inside {SIZE_H, SIZE_HU}) begin
      addr[0] = 1'b0;
    end
    if (size == SIZE_W) begin
      addr[1:0] = 2'b00;
    end
    case (r[1:0])
      2'd0:    op = make_op(1'b0, 1'b0, size, $random(seed), $random(seed), r[12]);
      2'd1:    op = make_op(1'b0, 1'b1, size, addr, $random(seed), 1'b0);
      default: op = make_op(1'b1, 1'b0, size, addr, 0, r[12]);
    endcase
    return op;
  endfunction

  // Holds the bundle until stall drops, then queues the expected writeback.
  task automatic issue_op(input ex_mem_t op);
    int   stalled;
    exp_t e;
    @(negedge clk_i);
    ex      = op;
    stalled = 0;
    #1;
    while (stall && stalled < timeout_cycles) begin
      stalled++;
      @(negedge clk_i);
      #1;
    end
    if (stall) begin
      $display("Timeout at %0t: stall_o never dropped", $time);
      errors++;
    end else begin
      assert (stalled == (op.is_load ? `MEM_RD_LAT : 0))
        else report_mismatch("stall_o cycles", op.is_load ? `MEM_RD_LAT : 0, stalled);
      e.wb    = expected_wb(op);
      e.cycle = cycle_cnt + 1;
      exp_q.push_back(e);
    end
  endtask

  task automatic close_test(input string name);
    int waited;
    @(negedge clk_i);
    ex     = '0;
    waited = 0;
    while (exp_q.size() != 0 && waited < timeout_cycles) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout in %s: %0d writebacks never arrived", name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    tests_run++;
    if (errors != test_start) begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, errors - test_start);
    end else begin
      $display("%s: PASS", name);
    end
    test_start = errors;
  endtask

  // Registered outputs are stable at the falling edge.
  always @(negedge clk_i) begin
    exp_t e;
    if (rst_i === 1'b1) begin
      if (exp_q.size() != 0 && exp_q[0].cycle < cycle_cnt) begin
        $display("Writeback missing at %0t, due in cycle %0d", $time, exp_q[0].cycle);
        errors++;
        void'(exp_q.pop_front());
      end
      if (wb.valid === 1'b1 && exp_q.size() == 0) begin
        $display("Unexpected writeback at %0t with data %h", $time, wb.data);
        errors++;
      end else if (wb.valid === 1'b1) begin
        e = exp_q.pop_front();
        assert (e.cycle == cycle_cnt) else report_mismatch("wb_o.valid cycle", e.cycle, cycle_cnt);
        assert (wb.reg_wr_en === e.wb.reg_wr_en)
          else report_mismatch("wb_o.reg_wr_en", 32'(e.wb.reg_wr_en), 32'(wb.reg_wr_en));
        assert (wb.wr_reg === e.wb.wr_reg)
          else report_mismatch("wb_o.wr_reg", 32'(e.wb.wr_reg), 32'(wb.wr_reg));
        assert (wb.data === e.wb.data) else report_mismatch("wb_o.data", e.wb.data, wb.data);
      end
    end
  end

  initial begin
    data_t rs2;
    int    n;
    seed         = 42104;
    errors       = 0;
    test_start   = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_cnt    = '0;
    ex           = '0;
    rst_i        = 1'b0;

    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      assert (wb.valid === 1'b0) else report_mismatch("wb_o.valid", 0, 32'(wb.valid));
    end
    rst_i = 1'b1;
    #1;
    n = 0;
    while (stall === 1'b1 && n < timeout_cycles) begin
      n++;
      @(negedge clk_i);
      #1;
    end
    assert (n == 1) else report_mismatch("stall_o cycles after reset", 1, n);
    assert (wb.valid === 1'b0) else report_mismatch("wb_o.valid", 0, 32'(wb.valid));
    close_test("reset");

    for (int i = 0; i < 4; i++) begin
      issue_op(make_op(1'b0, 1'b0, SIZE_W, $random(seed), 0, i[0]));
    end
    close_test("alu writeback");

    for (int i = 0; i < 4; i++) begin
      issue_op(make_op(1'b0, 1'b1, SIZE_W, 32'h200 + 4 * i, $random(seed), 1'b0));
      issue_op(make_op(1'b1, 1'b0, SIZE_W, 32'h200 + 4 * i, 0, 1'b0));
    end
    close_test("word store and load");

    for (int w = 0; w < 4; w++) begin
      for (int off = 0; off < 4; off++) begin
        rs2    = $random(seed);
        rs2[7] = off[0] ^ w[0];
        issue_op(make_op(1'b0, 1'b1, SIZE_B, 32'h240 + 4 * w + off, rs2, 1'b0));
        issue_op(make_op(1'b1, 1'b0, SIZE_B, 32'h240 + 4 * w + off, 0, 1'b0));
        issue_op(make_op(1'b1, 1'b0, SIZE_BU, 32'h240 + 4 * w + off, 0, 1'b0));
      end
      for (int off = 0; off < 4; off += 2) begin
        rs2     = $random(seed);
        rs2[15] = off[1] ^ w[0];
        issue_op(make_op(1'b0, 1'b1, SIZE_H, 32'h240 + 4 * w + off, rs2, 1'b0));
        issue_op(make_op(1'b1, 1'b0, SIZE_H, 32'h240 + 4 * w + off, 0, 1'b0));
        issue_op(make_op(1'b1, 1'b0, SIZE_HU, 32'h240 + 4 * w + off, 0, 1'b0));
      end
      issue_op(make_op(1'b1, 1'b0, SIZE_W, 32'h240 + 4 * w, 0, 1'b0));
    end
    close_test("sub-word loads");

    // Loads right behind a store and behind each other.
    for (int i = 0; i < 4; i++) begin
      issue_op(make_op(1'b0, 1'b1, SIZE_W, 32'h280, $random(seed), 1'b0));
      issue_op(make_op(1'b1, 1'b0, SIZE_W, 32'h280, 0, 1'b0));
      issue_op(make_op(1'b1, 1'b0, SIZE_H, 32'h282, 0, 1'b0));
    end
    close_test("load latency");

    for (int i = 0; i < 32; i++) begin
      issue_op(make_op(1'b0, 1'b1, SIZE_W, 32'h400 + 4 * i, $random(seed), 1'b0));
    end
    for (int i = 0; i < 200; i++) begin
      issue_op(random_op());
    end
    close_test("random operations");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_mem_subsys

// ==== vlog.f ====
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/mem_bus_pkg.sv
hdl/mem_stage.sv
hdl/dmem.sv
hdl/load_align.sv
hdl/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module tb_mem_subsys -Mdir obj_dir \
  && ./obj_dir/Vtb_mem_subsys | tee /dev/stderr \
    | grep "Simulation completed successfully" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
